// ==== hw/tx_macros.svh ====
`ifndef TX_MACROS_SVH
`define TX_MACROS_SVH

// Messages the software side can configure.
`define NUM_MSGS 4

// Transmit lanes working in parallel.
`define NUM_LANES 2

// Switch input buffer, in flits.
`define BUF_DEPTH 8

`define MEM_WORDS 64

`endif

// ==== hw/tx_mem_pkg.sv ====
`include "tx_macros.svh"

package tx_mem_pkg;

    // One packet memory word, also the flit payload.
    typedef logic [31:0] word_t;

    typedef logic [$clog2(`MEM_WORDS)-1:0] mem_addr_t;

    // Lane number.
    typedef logic [$clog2(`NUM_LANES)-1:0] lane_idx_t;

endpackage

// ==== hw/chiplet_types_pkg.sv ====
package chiplet_types_pkg;

    // Index into the message table.
    typedef logic [1:0] pkt_id_t;

    typedef logic [3:0] node_id_t;

    // Flits in a packet, header included.
    typedef logic [4:0] pkt_len_t;

    typedef logic [1:0] vc_t;

    typedef struct packed {
        vc_t      vc;
        pkt_id_t  id;
        node_id_t node;
    } flit_metadata_t;

    // Metadata on top, payload word below.
    typedef struct packed {
        flit_metadata_t    metadata;
        tx_mem_pkg::word_t payload;
    } flit_t;

    // Only the length field of a header is decoded.
    function automatic pkt_len_t hdr_length(tx_mem_pkg::word_t hdr);
        return hdr[$bits(pkt_len_t)-1:0];
    endfunction

endpackage

// ==== hw/tx_pkt_mem.sv ====
`timescale 1ns/1ns
`include "tx_macros.svh"

module tx_pkt_mem (
    input  logic                  clk,
    input  logic                  wen,
    input  tx_mem_pkg::mem_addr_t waddr,
    input  tx_mem_pkg::word_t     wdata,
    input  tx_mem_pkg::mem_addr_t rd_addr [`NUM_LANES],
    output tx_mem_pkg::word_t     rd_data [`NUM_LANES]
);
    import tx_mem_pkg::*;

    word_t mem [`MEM_WORDS];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // Combinational read, one port per lane.
    always_comb begin
        for (int l = 0; l < `NUM_LANES; l++) begin
            rd_data[l] = mem[rd_addr[l]];
        end
    end

endmodule

// ==== hw/msg_dispatch.sv ====
`timescale 1ns/1ns
`include "tx_macros.svh"

module msg_dispatch (
    input  logic                       clk,
    input  logic                       n_rst,
    input  logic                       cfg_wen,
    input  chiplet_types_pkg::pkt_id_t cfg_msg,
    input  tx_mem_pkg::mem_addr_t      cfg_addr,
    input  logic [`NUM_MSGS-1:0]       trigger_send,
    input  logic [`NUM_LANES-1:0]      lane_busy,
    output logic [`NUM_LANES-1:0]      lane_start,
    output chiplet_types_pkg::pkt_id_t lane_msg [`NUM_LANES],
    output tx_mem_pkg::mem_addr_t      lane_addr [`NUM_LANES]
);
    import chiplet_types_pkg::*;
    import tx_mem_pkg::*;

    mem_addr_t              start_addr [`NUM_MSGS];
    logic [`NUM_MSGS-1:0]   pending;
    logic [`NUM_MSGS-1:0]   pending_clr;
    logic [`NUM_LANES-1:0]  lane_idle;
    logic                   have_msg;
    logic                   have_lane;
    logic                   go;
    pkt_id_t                sel_msg;
    lane_idx_t              sel_lane;

    always_ff @(posedge clk) begin
        if (cfg_wen) begin
            start_addr[cfg_msg] <= cfg_addr;
        end
    end

    // A lane started last cycle has not raised busy yet.
    assign lane_idle = ~lane_busy & ~lane_start;

    always_comb begin
        have_msg = 1'b0;
        sel_msg = '0;
        for (int m = 0; m < `NUM_MSGS; m++) begin
            if (pending[m]) begin
                have_msg = 1'b1;
                sel_msg = pkt_id_t'(m);
            end
        end
        have_lane = 1'b0;
        sel_lane = '0;
        for (int l = `NUM_LANES - 1; l >= 0; l--) begin
            if (lane_idle[l]) begin
                have_lane = 1'b1;
                sel_lane = lane_idx_t'(l);
            end
        end
    end

    assign go = have_msg && have_lane;
    assign pending_clr = go ? (`NUM_MSGS'(1) << sel_msg) : '0;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pending <= '0;
            lane_start <= '0;
        end else begin
            // A new trigger wins over the clear.
            pending <= (pending & ~pending_clr) | trigger_send;
            lane_start <= go ? (`NUM_LANES'(1) << sel_lane) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            lane_msg[sel_lane] <= sel_msg;
            lane_addr[sel_lane] <= start_addr[sel_msg];
        end
    end

endmodule

// ==== hw/tx_fsm.sv ====
`timescale 1ns/1ns

module tx_fsm (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        start,
    input  chiplet_types_pkg::pkt_id_t  start_msg,
    input  tx_mem_pkg::mem_addr_t       start_addr,
    input  chiplet_types_pkg::node_id_t node_id,
    output tx_mem_pkg::mem_addr_t       rd_addr,
    input  tx_mem_pkg::word_t           rd_data,
    input  logic                        enable,
    output logic                        busy,
    output logic                        req,
    output logic                        send,
    output chiplet_types_pkg::flit_t    flit
);
    import chiplet_types_pkg::*;
    import tx_mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START_SEND,
        SEND
    } state_e;

    state_e    state;
    state_e    next_state;
    pkt_id_t   msg_q;
    mem_addr_t base_q;
    pkt_len_t  len_q;
    pkt_len_t  next_len;
    pkt_len_t  cnt_q;
    pkt_len_t  next_cnt;

    // Word index follows the flit count.
    assign rd_addr = base_q + mem_addr_t'(cnt_q);
    assign req = (state == SEND) && (cnt_q != len_q);
    assign send = req && enable;

    always_comb begin
        flit.payload = rd_data;
        flit.metadata.vc = '0;
        flit.metadata.id = msg_q;
        flit.metadata.node = node_id;
    end

    always_comb begin
        next_state = state;
        next_len = len_q;
        next_cnt = cnt_q;
        case (state)
            IDLE: begin
                if (start) begin
                    next_state = START_SEND;
                    next_cnt = '0;
                end
            end
            START_SEND: begin
                // Header is on rd_data here.
                next_len = hdr_length(rd_data);
                next_state = (next_len == '0) ? IDLE : SEND;
            end
            SEND: begin
                if (send) begin
                    next_cnt = cnt_q + 1'b1;
                    if (next_cnt == len_q) begin
                        next_state = IDLE;
                    end
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= IDLE;
            len_q <= '0;
            cnt_q <= '0;
            busy <= 1'b0;
        end else begin
            state <= next_state;
            len_q <= next_len;
            cnt_q <= next_cnt;
            // Lags the state by one cycle.
            busy <= start || (state != IDLE);
        end
    end

    always_ff @(posedge clk) begin
        if (start && (state == IDLE)) begin
            msg_q <= start_msg;
            base_q <= start_addr;
        end
    end

endmodule

// ==== hw/link_arbiter.sv ====
`timescale 1ns/1ns
`include "tx_macros.svh"

module link_arbiter (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic [`NUM_LANES-1:0]    lane_req,
    input  logic [`NUM_LANES-1:0]    lane_send,
    input  chiplet_types_pkg::flit_t lane_flit [`NUM_LANES],
    input  logic                     buffer_available,
    output logic [`NUM_LANES-1:0]    lane_enable,
    output chiplet_types_pkg::flit_t link_flit,
    output logic                     link_valid
);
    import chiplet_types_pkg::*;
    import tx_mem_pkg::*;

    localparam int CREDIT_LIMIT = 3 * `BUF_DEPTH / 4;

    // Flits sent since the switch last freed space.
    typedef logic [$clog2(`BUF_DEPTH):0] credit_cnt_t;

    lane_idx_t                    owner_q;
    lane_idx_t                    owner_next;
    lane_idx_t                    cand;
    credit_cnt_t                  sent_q;
    logic                         any_send;
    logic                         stop;
    flit_t                        sel_flit;

    assign any_send = |lane_send;
    assign stop = (sent_q >= CREDIT_LIMIT);
    assign lane_enable = stop ? '0 : (`NUM_LANES'(1) << owner_q);

    // Owner only moves between packets.
    always_comb begin
        owner_next = owner_q;
        cand = owner_q;
        if (!lane_req[owner_q]) begin
            for (int k = `NUM_LANES - 1; k >= 1; k--) begin
                cand = lane_idx_t'((int'(owner_q) + k) % `NUM_LANES);
                if (lane_req[cand]) begin
                    owner_next = cand;
                end
            end
        end
    end

    always_comb begin
        sel_flit = lane_flit[0];
        for (int l = 0; l < `NUM_LANES; l++) begin
            if (lane_send[l]) begin
                sel_flit = lane_flit[l];
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            owner_q <= '0;
            sent_q <= '0;
            link_valid <= 1'b0;
        end else begin
            owner_q <= owner_next;
            // A flit sent with the pulse still counts.
            if (buffer_available) begin
                sent_q <= credit_cnt_t'(any_send);
            end else if (any_send) begin
                sent_q <= sent_q + 1'b1;
            end
            link_valid <= any_send;
        end
    end

    always_ff @(posedge clk) begin
        if (any_send) begin
            link_flit <= sel_flit;
        end
    end

endmodule

// ==== hw/chiplet_tx_top.sv ====
`timescale 1ns/1ns
`include "tx_macros.svh"

module chiplet_tx_top (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        cfg_wen,
    input  chiplet_types_pkg::pkt_id_t  cfg_msg,
    input  tx_mem_pkg::mem_addr_t       cfg_addr,
    input  logic                        mem_wen,
    input  tx_mem_pkg::mem_addr_t       mem_waddr,
    input  tx_mem_pkg::word_t           mem_wdata,
    input  logic [`NUM_MSGS-1:0]        trigger_send,
    input  chiplet_types_pkg::node_id_t node_id,
    input  logic                        buffer_available,
    output chiplet_types_pkg::flit_t    link_flit,
    output logic                        link_valid
);
    import chiplet_types_pkg::*;
    import tx_mem_pkg::*;

    logic [`NUM_LANES-1:0] lane_start;
    logic [`NUM_LANES-1:0] lane_busy;
    logic [`NUM_LANES-1:0] lane_req;
    logic [`NUM_LANES-1:0] lane_send;
    logic [`NUM_LANES-1:0] lane_enable;
    pkt_id_t               lane_msg [`NUM_LANES];
    mem_addr_t             lane_addr [`NUM_LANES];
    mem_addr_t             rd_addr [`NUM_LANES];
    word_t                 rd_data [`NUM_LANES];
    flit_t                 lane_flit [`NUM_LANES];

    msg_dispatch u_dispatch (
        .clk          (clk),
        .n_rst        (n_rst),
        .cfg_wen      (cfg_wen),
        .cfg_msg      (cfg_msg),
        .cfg_addr     (cfg_addr),
        .trigger_send (trigger_send),
        .lane_busy    (lane_busy),
        .lane_start   (lane_start),
        .lane_msg     (lane_msg),
        .lane_addr    (lane_addr)
    );

    tx_pkt_mem u_mem (
        .clk     (clk),
        .wen     (mem_wen),
        .waddr   (mem_waddr),
        .wdata   (mem_wdata),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
        tx_fsm u_fsm (
            .clk        (clk),
            .n_rst      (n_rst),
            .start      (lane_start[l]),
            .start_msg  (lane_msg[l]),
            .start_addr (lane_addr[l]),
            .node_id    (node_id),
            .rd_addr    (rd_addr[l]),
            .rd_data    (rd_data[l]),
            .enable     (lane_enable[l]),
            .busy       (lane_busy[l]),
            .req        (lane_req[l]),
            .send       (lane_send[l]),
            .flit       (lane_flit[l])
        );
    end

    link_arbiter u_arb (
        .clk              (clk),
        .n_rst            (n_rst),
        .lane_req         (lane_req),
        .lane_send        (lane_send),
        .lane_flit        (lane_flit),
        .buffer_available (buffer_available),
        .lane_enable      (lane_enable),
        .link_flit        (link_flit),
        .link_valid       (link_valid)
    );

endmodule

// ==== testbench/tb_chiplet_tx.sv ====
`timescale 1ns/1ns
`include "tx_macros.svh"

module tb_chiplet_tx;
    import chiplet_types_pkg::*;
    import tx_mem_pkg::*;

    logic                 clk;
    logic                 n_rst;
    logic                 cfg_wen;
    pkt_id_t              cfg_msg;
    mem_addr_t            cfg_addr;
    logic                 mem_wen;
    mem_addr_t            mem_waddr;
    word_t                mem_wdata;
    logic [`NUM_MSGS-1:0] trigger_send;
    node_id_t             node_id;
    logic                 buffer_available;
    flit_t                link_flit;
    logic                 link_valid;

    // Memory image and expected words per message.
    word_t       tb_mem [`MEM_WORDS];
    mem_addr_t   msg_base [`NUM_MSGS];
    word_t       exp_q [`NUM_MSGS][$];
    int          exp_len [`NUM_MSGS];
    logic [31:0] lcg_state = 32'h306a740b;
    string       test_name = "reset";
    int          mismatches = 0;
    int          failures = 0;
    int          done_before;

    // Monitor results, settled at the falling edge.
    logic        quiet = 1'b1;
    logic        chk_valid = 1'b0;
    logic        have_exp = 1'b0;
    logic        in_order = 1'b1;
    word_t       exp_payload;
    word_t       act_payload;
    vc_t         act_vc;
    node_id_t    exp_node;
    node_id_t    act_node;
    pkt_id_t     act_id;
    pkt_id_t     cur_msg;
    int          flits_left = 0;
    int          pkts_done = 0;
    logic        credit_on = 1'b0;
    int          credit_cap = 0;
    int          credit_flits = 0;

    chiplet_tx_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic bit all_drained();
        for (int m = 0; m < `NUM_MSGS; m++) begin
            if (exp_q[m].size() != 0) begin
                return 1'b0;
            end
        end
        return flits_left == 0;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic write_word(mem_addr_t addr, word_t data);
        mem_wen = 1'b1;
        mem_waddr = addr;
        mem_wdata = data;
        tb_mem[addr] = data;
        tick();
        mem_wen = 1'b0;
    endtask

    // Header carries the flit count in its low 5 bits.
    task automatic load_packet(pkt_id_t m, mem_addr_t base, int len);
        word_t hdr;
        hdr = next_rand();
        hdr[4:0] = 5'(len);
        write_word(base, hdr);
        for (int i = 1; i < len; i++) begin
            write_word(base + mem_addr_t'(i), next_rand());
        end
        cfg_wen = 1'b1;
        cfg_msg = m;
        cfg_addr = base;
        msg_base[m] = base;
        tick();
        cfg_wen = 1'b0;
    endtask

    task automatic trigger(logic [`NUM_MSGS-1:0] mask);
        word_t hdr;
        int len;
        for (int m = 0; m < `NUM_MSGS; m++) begin
            if (mask[m]) begin
                hdr = tb_mem[msg_base[m]];
                len = int'(hdr[4:0]);
                for (int i = 0; i < len; i++) begin
                    exp_q[m].push_back(tb_mem[msg_base[m] + mem_addr_t'(i)]);
                end
                exp_len[m] = len;
            end
        end
        trigger_send = mask;
        quiet = 1'b0;
        tick();
        trigger_send = '0;
    endtask

    task automatic pulse_credit();
        buffer_available = 1'b1;
        tick();
        buffer_available = 1'b0;
    endtask

    task automatic wait_drained(int limit);
        int cycles;
        cycles = 0;
        while (!all_drained() && cycles < limit) begin
            // Switch frees space every fourth cycle.
            buffer_available = (cycles % 4 == 3);
            tick();
            cycles++;
        end
        buffer_available = 1'b0;
        if (!all_drained()) begin
            failures++;
            $display("timeout in %s: packets not sent within %0d cycles", test_name, limit);
        end
    endtask

    task automatic wait_flits(int target, int limit);
        int cycles;
        cycles = 0;
        while (credit_flits < target && cycles < limit) begin
            tick();
            cycles++;
        end
        if (credit_flits < target) begin
            failures++;
            $display("timeout in %s: only %0d of %0d flits arrived", test_name,
                     credit_flits, target);
        end
    endtask

    task automatic check_count(string what, int actual, int expected);
        assert (actual == expected)
            else begin
                mismatches++;
                $display("mismatch %s in %s: expected %0d actual %0d", what, test_name,
                         expected, actual);
            end
    endtask

    always @(negedge clk) begin
        chk_valid = n_rst && link_valid;
        if (chk_valid) begin
            act_payload = link_flit.payload;
            act_vc = link_flit.metadata.vc;
            act_id = link_flit.metadata.id;
            act_node = link_flit.metadata.node;
            exp_node = node_id;
            if (flits_left == 0) begin
                cur_msg = act_id;
                flits_left = exp_len[act_id];
                exp_len[act_id] = 0;
            end
            in_order = (act_id == cur_msg);
            have_exp = (flits_left > 0) && (exp_q[act_id].size() > 0);
            if (have_exp) begin
                exp_payload = exp_q[act_id].pop_front();
                flits_left--;
                if (flits_left == 0) begin
                    pkts_done++;
                end
            end
            if (credit_on) begin
                credit_flits++;
            end
        end
    end

    a_quiet: assert property (@(posedge clk) disable iff (!n_rst) !(quiet && link_valid))
        else begin
            failures++;
            $display("link_valid high in %s before any trigger", test_name);
        end

    a_known: assert property (@(posedge clk) !chk_valid || have_exp)
        else begin
            failures++;
            $display("flit of message %0d in %s with no packet outstanding", act_id, test_name);
        end

    a_payload: assert property (@(posedge clk) !(chk_valid && have_exp) || act_payload == exp_payload)
        else begin
            mismatches++;
            $display("mismatch payload in %s: expected %h actual %h", test_name, exp_payload,
                     act_payload);
        end

    a_vc: assert property (@(posedge clk) !chk_valid || act_vc == '0)
        else begin
            mismatches++;
            $display("mismatch vc in %s: expected 0 actual %0d", test_name, act_vc);
        end

    a_node: assert property (@(posedge clk) !chk_valid || act_node == exp_node)
        else begin
            mismatches++;
            $display("mismatch node_id in %s: expected %h actual %h", test_name, exp_node,
                     act_node);
        end

    a_contig: assert property (@(posedge clk) !chk_valid || in_order)
        else begin
            failures++;
            $display("message %0d flit inside packet of message %0d in %s", act_id, cur_msg,
                     test_name);
        end

    a_credit: assert property (@(posedge clk) !(credit_on && credit_flits > credit_cap))
        else begin
            failures++;
            $display("more than %0d flits sent in %s without free buffer space", credit_cap,
                     test_name);
        end

    initial begin
        n_rst = 1'b0;
        cfg_wen = 1'b0;
        cfg_msg = '0;
        cfg_addr = '0;
        mem_wen = 1'b0;
        mem_waddr = '0;
        mem_wdata = '0;
        trigger_send = '0;
        node_id = 4'h9;
        buffer_available = 1'b0;
        for (int m = 0; m < `NUM_MSGS; m++) begin
            exp_len[m] = 0;
        end
        repeat (8) @(posedge clk);
        #1;
        n_rst = 1'b1;

        test_name = "single";
        for (int m = 0; m < `NUM_MSGS; m++) begin
            load_packet(pkt_id_t'(m), mem_addr_t'(m * 8), int'(next_rand() % 32'd6) + 1);
        end
        done_before = pkts_done;
        trigger(4'b0001);
        wait_drained(200);
        check_count("packet count", pkts_done - done_before, 1);

        test_name = "all four";
        node_id = 4'h3;
        done_before = pkts_done;
        trigger(4'b1111);
        wait_drained(400);
        check_count("packet count", pkts_done - done_before, 4);

        // Lengths 4 to 6 so the four packets exceed two credit windows.
        test_name = "credit";
        for (int m = 0; m < `NUM_MSGS; m++) begin
            load_packet(pkt_id_t'(m), mem_addr_t'(m * 8), int'(next_rand() % 32'd3) + 4);
        end
        pulse_credit();
        done_before = pkts_done;
        credit_flits = 0;
        credit_cap = 3 * `BUF_DEPTH / 4;
        credit_on = 1'b1;
        trigger(4'b1111);
        wait_flits(credit_cap, 200);
        repeat (30) tick();
        check_count("flits before credit", credit_flits, credit_cap);
        credit_cap = 2 * (3 * `BUF_DEPTH / 4);
        pulse_credit();
        wait_flits(credit_cap, 200);
        repeat (30) tick();
        check_count("flits after one credit", credit_flits, credit_cap);
        credit_on = 1'b0;
        wait_drained(400);
        check_count("packet count", pkts_done - done_before, 4);

        test_name = "readdress";
        load_packet(2'd2, 6'd40, int'(next_rand() % 32'd6) + 1);
        done_before = pkts_done;
        trigger(4'b0100);
        wait_drained(200);
        check_count("packet count", pkts_done - done_before, 1);

        $display("closing: %0d mismatches, %0d other failures, %0d packets checked",
                 mismatches, failures, pkts_done);
        if (mismatches == 0 && failures == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hw
hw/tx_mem_pkg.sv
hw/chiplet_types_pkg.sv
hw/tx_pkt_mem.sv
hw/msg_dispatch.sv
hw/tx_fsm.sv
hw/link_arbiter.sv
hw/chiplet_tx_top.sv
testbench/tb_chiplet_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module tb_chiplet_tx \
        -f all.f -o sim_tx > build.log 2>&1 \
    && ./obj_dir/sim_tx > sim.log 2>&1 \
    || { echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "SOME TESTS FAILED" sim.log \
    && { echo "simulation reported failures, see sim.log"; exit 1; }
echo "simulation clean, see sim.log"
exit 0
